// ==== ctrl_decode.sv ====
// Combinational control decode; lsu_ctrl is formed for every opcode, unused addresses are zero
`timescale 1ns/1ps

module ctrl_decode
  import rv_decode_pkg::*;
(
  input  word_t                     instr_i,
  // ALU side
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o,
  output reg_addr_t                 alu_dest_addr_o,
  output logic                      alu_wb_o,
  // Register file side
  output reg_addr_t                 rf_addr_a_o,
  output reg_addr_t                 rf_addr_b_o,
  // Load/store side
  output logic                      lsu_new_ctrl_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output reg_addr_t                 lsu_regdest_o,
  output logic                      illegal_instr_o,
  // Register usage for the hazard check
  output logic                      rs1_used_o,
  output logic                      rs2_used_o,
  output logic                      rd_written_o
);

  opcode_t                 opcode;
  logic [FUNCT3_WIDTH-1:0] funct3;
  reg_addr_t               rd;
  reg_addr_t               rs1;
  reg_addr_t               rs2;

  assign opcode = instr_i[OPCODE_WIDTH-1:0];
  assign funct3 = instr_i[FUNCT3_LSB +: FUNCT3_WIDTH];
  assign rd     = instr_i[RD_LSB +: REG_ADDR_WIDTH];
  assign rs1    = instr_i[RS1_LSB +: REG_ADDR_WIDTH];
  assign rs2    = instr_i[RS2_LSB +: REG_ADDR_WIDTH];

  // Bit 5 of the opcode tells a store from a load
  assign lsu_ctrl_o = {instr_i[LSU_DIR_BIT], funct3};

  assign is_imm_o = (opcode != OPCODE_OP);  // Only OP takes operand b from rs2

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    // Defaults describe an illegal instruction
    alu_sel_o       = ALU_OP_ADD;
    use_pc_o        = 1'b0;
    alu_dest_addr_o = '0;
    alu_wb_o        = 1'b0;
    rf_addr_a_o     = '0;
    rf_addr_b_o     = '0;
    lsu_new_ctrl_o  = 1'b0;
    lsu_regdest_o   = '0;
    illegal_instr_o = 1'b0;
    rs1_used_o      = 1'b0;
    rs2_used_o      = 1'b0;
    rd_written_o    = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        alu_sel_o       = {instr_i[ALT_OP_BIT], funct3};
        alu_dest_addr_o = rd;
        alu_wb_o        = 1'b1;
        rf_addr_a_o     = rs1;
        rf_addr_b_o     = rs2;
        rs1_used_o      = 1'b1;
        rs2_used_o      = 1'b1;
        rd_written_o    = 1'b1;
      end
      OPCODE_OPIMM: begin
        // Only SRAI uses the alternate bit; in other forms bit 30 is immediate
        if (funct3 == FUNCT3_SRL_SRA) begin
          alu_sel_o = {instr_i[ALT_OP_BIT], funct3};
        end else begin
          alu_sel_o = {1'b0, funct3};
        end
        alu_dest_addr_o = rd;
        alu_wb_o        = 1'b1;
        rf_addr_a_o     = rs1;
        rs1_used_o      = 1'b1;
        rd_written_o    = 1'b1;
      end
      OPCODE_LUI: begin
        alu_dest_addr_o = rd;  // x0 + immediate
        alu_wb_o        = 1'b1;
        rd_written_o    = 1'b1;
      end
      OPCODE_AUIPC: begin
        use_pc_o        = 1'b1;  // PC replaces operand a
        alu_dest_addr_o = rd;
        alu_wb_o        = 1'b1;
        rd_written_o    = 1'b1;
      end
      OPCODE_LOAD: begin
        rf_addr_a_o    = rs1;  // Address base
        lsu_new_ctrl_o = 1'b1;
        lsu_regdest_o  = rd;   // Written back by the LSU
        rs1_used_o     = 1'b1;
        rd_written_o   = 1'b1;
      end
      OPCODE_STORE: begin
        rf_addr_a_o    = rs1;
        rf_addr_b_o    = rs2;  // Store data
        lsu_new_ctrl_o = 1'b1;
        rs1_used_o     = 1'b1;
        rs2_used_o     = 1'b1;
      end
      default: begin
        illegal_instr_o = 1'b1;
      end
    endcase
  end

endmodule : ctrl_decode

// ==== decode_out_reg.sv ====
// Output register; strobes last one cycle per issue, other fields hold until the next issue
`timescale 1ns/1ps

module decode_out_reg
  import rv_decode_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      issue_i,
  input  word_t                     instr_addr_i,
  input  logic [ALU_OP_WIDTH-1:0]   alu_sel_i,
  input  logic                      is_imm_i,
  input  logic                      use_pc_i,
  input  reg_addr_t                 alu_dest_addr_i,
  input  logic                      alu_wb_i,
  input  reg_addr_t                 rf_addr_a_i,
  input  reg_addr_t                 rf_addr_b_i,
  input  word_t                     imm_ext_i,
  input  logic                      lsu_new_ctrl_i,
  input  logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_i,
  input  reg_addr_t                 lsu_regdest_i,
  input  logic                      illegal_instr_i,
  output word_t                     instr_addr_o,
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o,
  output reg_addr_t                 alu_dest_addr_o,
  output logic                      alu_wb_o,
  output reg_addr_t                 rf_addr_a_o,
  output reg_addr_t                 rf_addr_b_o,
  output word_t                     imm_ext_o,
  output logic                      lsu_new_ctrl_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output reg_addr_t                 lsu_regdest_o,
  output logic                      illegal_instr_o
);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_addr_o    <= '0;
      alu_sel_o       <= '0;
      is_imm_o        <= 1'b0;
      use_pc_o        <= 1'b0;
      alu_dest_addr_o <= '0;
      alu_wb_o        <= 1'b0;
      rf_addr_a_o     <= '0;
      rf_addr_b_o     <= '0;
      imm_ext_o       <= '0;
      lsu_new_ctrl_o  <= 1'b0;
      lsu_ctrl_o      <= '0;
      lsu_regdest_o   <= '0;
      illegal_instr_o <= 1'b0;
    end else begin
      instr_addr_o <= instr_addr_i;  // Follows fetch every cycle
      if (issue_i) begin
        alu_sel_o       <= alu_sel_i;
        is_imm_o        <= is_imm_i;
        use_pc_o        <= use_pc_i;
        alu_dest_addr_o <= alu_dest_addr_i;
        alu_wb_o        <= alu_wb_i;
        rf_addr_a_o     <= rf_addr_a_i;
        rf_addr_b_o     <= rf_addr_b_i;
        imm_ext_o       <= imm_ext_i;
        lsu_new_ctrl_o  <= lsu_new_ctrl_i;
        lsu_ctrl_o      <= lsu_ctrl_i;
        lsu_regdest_o   <= lsu_regdest_i;
        illegal_instr_o <= illegal_instr_i;
      end else begin
        // Bubble: nothing starts downstream
        alu_wb_o       <= 1'b0;
        lsu_new_ctrl_o <= 1'b0;
        use_pc_o       <= 1'b0;
      end
    end
  end

endmodule : decode_out_reg

// ==== decoder_chk.sv ====
// Protocol assertions bound into the decoder top; checks only while out of reset
`timescale 1ns/1ps

module decoder_chk (
  input logic clk_i,
  input logic rstn_i,
  input logic ready_o,
  input logic alu_wb_o,
  input logic lsu_new_ctrl_o,
  input logic use_pc_o,
  input logic illegal_instr_o
);

  // A stalled instruction issues on its second cycle
  assert property (@(posedge clk_i) disable iff (!rstn_i) !ready_o |=> ready_o)
    else $error("ready_o low in two consecutive cycles");

  assert property (@(posedge clk_i) disable iff (!rstn_i) !(alu_wb_o && lsu_new_ctrl_o))
    else $error("alu_wb_o and lsu_new_ctrl_o high together");

  assert property (@(posedge clk_i) disable iff (!rstn_i)
                   illegal_instr_o |-> !(alu_wb_o || lsu_new_ctrl_o || use_pc_o))
    else $error("Strobe high with illegal_instr_o");

  // First edge after reset release sees the reset values
  assert property (@(posedge clk_i) $rose(rstn_i) |-> !(alu_wb_o || lsu_new_ctrl_o || use_pc_o))
    else $error("Strobe high right after reset");

endmodule : decoder_chk

bind rv_decoder_top decoder_chk chk0 (.*);

// ==== hazard_detect.sv ====
// One-cycle stall on a read of the last issued rd; no forwarding, x0 never stalls
`timescale 1ns/1ps

module hazard_detect
  import rv_decode_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  logic      rs1_used_i,
  input  logic      rs2_used_i,
  input  logic      rd_written_i,
  output logic      ready_o,
  output logic      issue_o
);

  reg_addr_t last_rd_q;   // Destination of the last issued instruction
  logic      stalled_q;   // Previous cycle was a stall
  logic      rs1_hit;
  logic      rs2_hit;
  logic      stall;

  assign rs1_hit = rs1_used_i && (rs1_i != '0) && (rs1_i == last_rd_q);
  assign rs2_hit = rs2_used_i && (rs2_i != '0) && (rs2_i == last_rd_q);

  // A held instruction never stalls twice
  assign stall = instr_valid_i && !stalled_q && (rs1_hit || rs2_hit);

  assign ready_o = !stall;
  assign issue_o = instr_valid_i && !stall;

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd_q <= '0;
      stalled_q <= 1'b0;
    end else begin
      stalled_q <= stall;
      if (issue_o) begin
        last_rd_q <= rd_written_i ? rd_i : '0;  // Stores leave nothing behind
      end
    end
  end

endmodule : hazard_detect

// ==== imm_gen.sv ====
// Combinational immediate builder; OP and unknown opcodes give zero, no B/J formats
`timescale 1ns/1ps

module imm_gen
  import rv_decode_pkg::*;
(
  input  word_t instr_i,
  output word_t imm_ext_o
);

  opcode_t                  opcode;
  logic [FUNCT3_WIDTH-1:0]  funct3;
  logic                     is_shift;
  word_t                    i_imm;
  word_t                    shamt_imm;
  word_t                    s_imm;
  word_t                    u_imm;

  assign opcode = instr_i[OPCODE_WIDTH-1:0];
  assign funct3 = instr_i[FUNCT3_LSB +: FUNCT3_WIDTH];

  // SLLI, SRLI and SRAI carry a shift amount instead of an immediate
  assign is_shift = (funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRL_SRA);

  //////////////////////////////////////////////////////////////////////
  // Format builders
  //////////////////////////////////////////////////////////////////////
  assign i_imm = {{(DATA_WIDTH-12){instr_i[31]}}, instr_i[31:20]};

  // Shift amount is unsigned
  assign shamt_imm = {{(DATA_WIDTH-SHAMT_WIDTH){1'b0}}, instr_i[RS2_LSB +: SHAMT_WIDTH]};

  assign s_imm = {{(DATA_WIDTH-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  assign u_imm = {instr_i[31:12], 12'b0};  // Upper 20 bits, low part zero

  //////////////////////////////////////////////////////////////////////
  // Format select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (opcode)
      OPCODE_LOAD: begin
        imm_ext_o = i_imm;
      end
      OPCODE_OPIMM: begin
        if (is_shift) begin
          imm_ext_o = shamt_imm;
        end else begin
          imm_ext_o = i_imm;
        end
      end
      OPCODE_STORE: begin
        imm_ext_o = s_imm;
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        imm_ext_o = u_imm;
      end
      default: begin
        imm_ext_o = '0;  // OP and illegal opcodes
      end
    endcase
  end

endmodule : imm_gen

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_rv_decoder -f verilog.f --Mdir obj_dir

./obj_dir/Vtb_rv_decoder

// ==== rv_decode_pkg.sv ====
// RV32I decode constants; only OP, OP-IMM, LUI, AUIPC, LOAD and STORE are known here
package rv_decode_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int DATA_WIDTH     = 32;  // Instruction, address and immediate
  localparam int REG_ADDR_WIDTH = 5;
  localparam int ALU_OP_WIDTH   = 4;   // Alternate bit plus funct3
  localparam int LSU_CTRL_WIDTH = 4;   // Direction bit plus funct3
  localparam int OPCODE_WIDTH   = 7;
  localparam int FUNCT3_WIDTH   = 3;
  localparam int SHAMT_WIDTH    = 5;

  //////////////////////////////////////////////////////////////////////
  // Field positions within the instruction word
  //////////////////////////////////////////////////////////////////////
  localparam int RD_LSB      = 7;
  localparam int FUNCT3_LSB  = 12;
  localparam int RS1_LSB     = 15;
  localparam int RS2_LSB     = 20;
  localparam int ALT_OP_BIT  = 30;  // SUB and SRA/SRAI select
  localparam int LSU_DIR_BIT = 5;   // Opcode bit, set for stores

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////
  typedef logic [OPCODE_WIDTH-1:0]   opcode_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [DATA_WIDTH-1:0]     word_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////
  localparam opcode_t OPCODE_LOAD  = 7'b000_0011;
  localparam opcode_t OPCODE_OPIMM = 7'b001_0011;
  localparam opcode_t OPCODE_AUIPC = 7'b001_0111;
  localparam opcode_t OPCODE_STORE = 7'b010_0011;
  localparam opcode_t OPCODE_OP    = 7'b011_0011;
  localparam opcode_t OPCODE_LUI   = 7'b011_0111;

  // Shift function codes, the only OP-IMM forms with a shamt field
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_SLL     = 3'b001;
  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_SRL_SRA = 3'b101;

  // ALU select codes
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_ADD = 4'b0000;

endpackage : rv_decode_pkg

// ==== rv_decoder_top.sv ====
// RV32I decoder top; fetch must hold instruction and valid while ready_o is low
`timescale 1ns/1ps

module rv_decoder_top
  import rv_decode_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rstn_i,
  // Fetch side
  input  word_t                     instr_i,
  input  word_t                     instr_addr_i,
  input  logic                      instr_valid_i,
  output logic                      ready_o,
  output word_t                     instr_addr_o,
  output logic                      illegal_instr_o,
  // ALU side
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      is_imm_o,
  output logic                      use_pc_o,
  output reg_addr_t                 alu_dest_addr_o,
  output logic                      alu_wb_o,
  // Register file side
  output reg_addr_t                 rf_addr_a_o,
  output reg_addr_t                 rf_addr_b_o,
  output word_t                     imm_ext_o,
  // Load/store side
  output logic                      lsu_new_ctrl_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output reg_addr_t                 lsu_regdest_o
);

  word_t                     imm_ext;
  logic [ALU_OP_WIDTH-1:0]   alu_sel;
  logic                      is_imm, use_pc, alu_wb, lsu_new_ctrl, illegal_instr;
  reg_addr_t                 alu_dest_addr, rf_addr_a, rf_addr_b, lsu_regdest;
  logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl;
  logic                      rs1_used, rs2_used, rd_written;
  logic                      issue;

  imm_gen u_imm_gen (.instr_i(instr_i), .imm_ext_o(imm_ext));

  ctrl_decode u_ctrl_decode (
    .instr_i(instr_i), .alu_sel_o(alu_sel), .is_imm_o(is_imm), .use_pc_o(use_pc),
    .alu_dest_addr_o(alu_dest_addr), .alu_wb_o(alu_wb), .rf_addr_a_o(rf_addr_a),
    .rf_addr_b_o(rf_addr_b), .lsu_new_ctrl_o(lsu_new_ctrl), .lsu_ctrl_o(lsu_ctrl),
    .lsu_regdest_o(lsu_regdest), .illegal_instr_o(illegal_instr),
    .rs1_used_o(rs1_used), .rs2_used_o(rs2_used), .rd_written_o(rd_written)
  );

  // Unused read addresses are zero, so the RF addresses double as source fields
  hazard_detect u_hazard_detect (
    .clk_i(clk_i), .rstn_i(rstn_i), .instr_valid_i(instr_valid_i),
    .rs1_i(rf_addr_a), .rs2_i(rf_addr_b), .rd_i(instr_i[RD_LSB +: REG_ADDR_WIDTH]),
    .rs1_used_i(rs1_used), .rs2_used_i(rs2_used), .rd_written_i(rd_written),
    .ready_o(ready_o), .issue_o(issue)
  );

  decode_out_reg u_decode_out_reg (
    .clk_i(clk_i), .rstn_i(rstn_i), .issue_i(issue), .instr_addr_i(instr_addr_i),
    .alu_sel_i(alu_sel), .is_imm_i(is_imm), .use_pc_i(use_pc),
    .alu_dest_addr_i(alu_dest_addr), .alu_wb_i(alu_wb), .rf_addr_a_i(rf_addr_a),
    .rf_addr_b_i(rf_addr_b), .imm_ext_i(imm_ext), .lsu_new_ctrl_i(lsu_new_ctrl),
    .lsu_ctrl_i(lsu_ctrl), .lsu_regdest_i(lsu_regdest), .illegal_instr_i(illegal_instr),
    .instr_addr_o(instr_addr_o), .alu_sel_o(alu_sel_o), .is_imm_o(is_imm_o),
    .use_pc_o(use_pc_o), .alu_dest_addr_o(alu_dest_addr_o), .alu_wb_o(alu_wb_o),
    .rf_addr_a_o(rf_addr_a_o), .rf_addr_b_o(rf_addr_b_o), .imm_ext_o(imm_ext_o),
    .lsu_new_ctrl_o(lsu_new_ctrl_o), .lsu_ctrl_o(lsu_ctrl_o),
    .lsu_regdest_o(lsu_regdest_o), .illegal_instr_o(illegal_instr_o)
  );

endmodule : rv_decoder_top

// ==== tb_rv_decoder.sv ====
// Random self-checking testbench; registers limited to x0-x3 so hazards are frequent
`timescale 1ns/1ps

module tb_rv_decoder
  import rv_decode_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int N_INSTR    = 2000;
  localparam int TIMEOUT_NS = (2 * N_INSTR + 20) * CLK_PERIOD;

  logic clk, rstn, instr_valid, ready, illegal, is_imm, use_pc, alu_wb, lsu_new;
  word_t instr, instr_addr, instr_addr_q, imm_ext;
  logic [ALU_OP_WIDTH-1:0] alu_sel;
  logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl;
  reg_addr_t alu_dest, rf_a, rf_b, lsu_regdest;

  // Reference model state
  logic [31:0] lfsr;
  logic d_illegal, d_is_imm, d_use_pc, d_alu_wb, d_lsu_new, d_rs1_used, d_rs2_used, d_rd_written;
  logic [ALU_OP_WIDTH-1:0] d_alu_sel, exp_alu_sel;
  logic [LSU_CTRL_WIDTH-1:0] d_lsu_ctrl, exp_lsu_ctrl;
  reg_addr_t d_alu_dest, d_rf_a, d_rf_b, d_lsu_regdest, m_last_rd;
  reg_addr_t exp_alu_dest, exp_rf_a, exp_rf_b, exp_lsu_regdest;
  word_t d_imm, exp_imm, exp_instr_addr;
  logic exp_illegal, exp_is_imm, exp_use_pc, exp_alu_wb, exp_lsu_new;
  logic m_stalled, stall, issue, hold;
  int issued;

  rv_decoder_top dut0 (
    .clk_i(clk), .rstn_i(rstn), .instr_i(instr), .instr_addr_i(instr_addr),
    .instr_valid_i(instr_valid), .ready_o(ready), .instr_addr_o(instr_addr_q),
    .illegal_instr_o(illegal), .alu_sel_o(alu_sel), .is_imm_o(is_imm), .use_pc_o(use_pc),
    .alu_dest_addr_o(alu_dest), .alu_wb_o(alu_wb), .rf_addr_a_o(rf_a), .rf_addr_b_o(rf_b),
    .imm_ext_o(imm_ext), .lsu_new_ctrl_o(lsu_new), .lsu_ctrl_o(lsu_ctrl),
    .lsu_regdest_o(lsu_regdest)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Fibonacci LFSR with taps 32, 22, 2 and 1
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("ERROR: %s expected 0x%08h got 0x%08h", name, exp_val, act_val);
      $display("STATUS: FAIL");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  // Decode rules for the six known opcodes
  task automatic decode_ref(input word_t ins);
    opcode_t op;
    logic [2:0] f3;
    op = ins[6:0];
    f3 = ins[14:12];
    d_illegal = !(op inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
                             OPCODE_LOAD, OPCODE_STORE});
    d_alu_wb = op inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC};
    d_lsu_new = op inside {OPCODE_LOAD, OPCODE_STORE};
    d_rd_written = d_alu_wb || (op == OPCODE_LOAD);
    d_rs1_used = op inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LOAD, OPCODE_STORE};
    d_rs2_used = op inside {OPCODE_OP, OPCODE_STORE};
    d_use_pc = (op == OPCODE_AUIPC);
    d_is_imm = (op != OPCODE_OP);
    d_alu_dest = d_alu_wb ? ins[11:7] : 5'd0;
    d_rf_a = d_rs1_used ? ins[19:15] : 5'd0;
    d_rf_b = d_rs2_used ? ins[24:20] : 5'd0;
    d_lsu_regdest = (op == OPCODE_LOAD) ? ins[11:7] : 5'd0;
    d_lsu_ctrl = {ins[5], f3};  // Store flag from opcode bit 5
    d_alu_sel = '0;
    if (op == OPCODE_OP || (op == OPCODE_OPIMM && f3 == 3'b101)) begin
      d_alu_sel = {ins[30], f3};
    end else if (op == OPCODE_OPIMM) begin
      d_alu_sel = {1'b0, f3};
    end
    case (op)
      OPCODE_LOAD:  d_imm = {{20{ins[31]}}, ins[31:20]};
      OPCODE_STORE: d_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      OPCODE_OPIMM: d_imm = (f3 == 3'b001 || f3 == 3'b101) ? {27'd0, ins[24:20]}
                                                            : {{20{ins[31]}}, ins[31:20]};
      OPCODE_LUI, OPCODE_AUIPC: d_imm = {ins[31:12], 12'd0};
      default:      d_imm = '0;
    endcase
  endtask

  task automatic pick_instr();
    logic [31:0] r, funct7, funct3;
    opcode_t op;
    rand_bits(2, r);
    instr_valid = (r[1:0] != 2'b00);  // About three quarters valid
    rand_bits(3, r);
    case (r[2:0])
      3'd0: op = OPCODE_OP;
      3'd1: op = OPCODE_OPIMM;
      3'd2: op = OPCODE_LUI;
      3'd3: op = OPCODE_AUIPC;
      3'd4: op = OPCODE_LOAD;
      3'd5: op = OPCODE_STORE;
      default: begin
        rand_bits(7, r);
        op = r[6:0];
      end
    endcase
    rand_bits(7, funct7);
    rand_bits(3, funct3);
    rand_bits(6, r);
    instr = {funct7[6:0], 3'd0, r[5:4], 3'd0, r[3:2], funct3[2:0], 3'd0, r[1:0], op};
    rand_bits(32, r);
    instr_addr = r;
  endtask

  task automatic check_outputs();
    check_value("instr_addr_o", exp_instr_addr, instr_addr_q);
    check_value("illegal_instr_o", 32'(exp_illegal), 32'(illegal));
    check_value("alu_sel_o", 32'(exp_alu_sel), 32'(alu_sel));
    check_value("is_imm_o", 32'(exp_is_imm), 32'(is_imm));
    check_value("use_pc_o", 32'(exp_use_pc), 32'(use_pc));
    check_value("alu_dest_addr_o", 32'(exp_alu_dest), 32'(alu_dest));
    check_value("alu_wb_o", 32'(exp_alu_wb), 32'(alu_wb));
    check_value("rf_addr_a_o", 32'(exp_rf_a), 32'(rf_a));
    check_value("rf_addr_b_o", 32'(exp_rf_b), 32'(rf_b));
    check_value("imm_ext_o", exp_imm, imm_ext);
    check_value("lsu_new_ctrl_o", 32'(exp_lsu_new), 32'(lsu_new));
    check_value("lsu_ctrl_o", 32'(exp_lsu_ctrl), 32'(lsu_ctrl));
    check_value("lsu_regdest_o", 32'(exp_lsu_regdest), 32'(lsu_regdest));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    instr = '0;
    instr_addr = '0;
    instr_valid = 1'b0;
    lfsr = 32'hcf0b_7a6a;
    {exp_illegal, exp_is_imm, exp_use_pc, exp_alu_wb, exp_lsu_new} = '0;
    {exp_alu_sel, exp_lsu_ctrl, exp_alu_dest, exp_rf_a, exp_rf_b, exp_lsu_regdest} = '0;
    exp_imm = '0;
    exp_instr_addr = '0;
    {m_last_rd, m_stalled, hold} = '0;
    issued = 0;
    repeat (2) @(posedge clk);
    #1 rstn = 1'b1;
    check_outputs();  // Reset values
    while (issued < N_INSTR) begin
      if (!hold) begin
        pick_instr();  // Held instruction repeats after a stall
      end
      #1;
      decode_ref(instr);
      stall = instr_valid && !m_stalled &&
              ((d_rs1_used && instr[19:15] != 5'd0 && instr[19:15] == m_last_rd) ||
               (d_rs2_used && instr[24:20] != 5'd0 && instr[24:20] == m_last_rd));
      issue = instr_valid && !stall;
      check_value("ready_o", 32'(!stall), 32'(ready));
      exp_instr_addr = instr_addr;
      {exp_use_pc, exp_alu_wb, exp_lsu_new} = '0;
      if (issue) begin
        {exp_illegal, exp_is_imm, exp_use_pc, exp_alu_wb, exp_lsu_new} =
          {d_illegal, d_is_imm, d_use_pc, d_alu_wb, d_lsu_new};
        {exp_alu_sel, exp_lsu_ctrl, exp_imm} = {d_alu_sel, d_lsu_ctrl, d_imm};
        {exp_alu_dest, exp_rf_a, exp_rf_b, exp_lsu_regdest} =
          {d_alu_dest, d_rf_a, d_rf_b, d_lsu_regdest};
        m_last_rd = d_rd_written ? instr[11:7] : 5'd0;
        issued++;
      end
      m_stalled = stall;
      hold = stall;
      @(posedge clk);
      #1 check_outputs();
    end
    $display("STATUS: PASS");
    $finish;
  end

  // Watchdog allows two cycles per instruction plus margin
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the decoder did not issue all instructions in time");
    $display("STATUS: FAIL");
    $fatal(1, "Simulation timed out");
  end

endmodule : tb_rv_decoder

// ==== verilog.f ====
rv_decode_pkg.sv
imm_gen.sv
ctrl_decode.sv
hazard_detect.sv
decode_out_reg.sv
rv_decoder_top.sv
decoder_chk.sv
tb_rv_decoder.sv
